//--- bench/icache_trace.txt
# cmd addr value (hex). F fetch, value 1 expects a hit, 0 a miss or bypassed refill
# B bypass level in value. X flush. C trans total in addr, value[15:8] hits, value[7:0] misses
F 00000104 0
F 00000108 1
F 00000110 0
F 00000210 0
F 00000310 0
F 00000214 1
F 0000031c 1
F 00000110 0
F 00000100 1
C 00000009 0405
X 00000000 0
F 00000100 0
F 00000100 1
B 00000000 1
F 00000100 0
F 00000310 0
B 00000000 0
F 00000100 0
F 00000100 1
C 0000000f 0607

//--- bench/tb_pri_icache.sv
// Testbench with clock, reset, refill memory model, trace checks and watchdog for the instruction cache
`timescale 1ns/1ps

module tb_pri_icache;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    fetch_req_i;
   icache_pkg::fetch_addr_t fetch_addr_i;
   logic                    fetch_gnt_o;
   logic                    fetch_rvalid_o;
   icache_pkg::line_t       fetch_rdata_o;
   logic                    refill_req_o;
   icache_pkg::fetch_addr_t refill_addr_o;
   logic                    refill_gnt_i;
   logic                    refill_r_valid_i;
   icache_pkg::line_t       refill_r_data_i;
   logic                    bypass_icache_i;
   logic                    flush_icache_i;
   logic                    ctrl_clear_regs_i;
   logic                    ctrl_enable_regs_i;
   logic                    cache_is_bypassed_o;
   logic                    cache_is_flushed_o;
   logic [31:0]             bank_hit_count_o;
   logic [31:0]             bank_trans_count_o;
   logic [31:0]             bank_miss_count_o;

   // One trace entry per command line
   logic [7:0]              trace_cmd [$];
   logic [31:0]             trace_addr [$];
   logic [31:0]             trace_val [$];
   logic                    trace_loaded = 1'b0;

   int                      mismatch_cnt = 0;
   int                      other_cnt = 0;
   // Refill requests seen and the address of the last one
   int                      refill_cnt = 0;
   icache_pkg::fetch_addr_t last_refill_addr;
   logic                    bypass_on = 1'b0;
   logic [15:0]             lfsr_q = 16'd53621;

   pri_icache i_pri_icache (.*);

   always #5 clk_i = ~clk_i;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
   function automatic logic [3:0] lfsr_take(input int nbits);
      logic fb;
      lfsr_take = '0;
      for (int i = 0; i < nbits; i++)
      begin
         fb        = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q    = {lfsr_q[14:0], fb};
         lfsr_take = {lfsr_take[2:0], fb};
      end
   endfunction

   // Program memory returns the line address in all four words
   function automatic icache_pkg::line_t line_data(input icache_pkg::fetch_addr_t addr);
      icache_pkg::fetch_addr_t base;
      base = {addr[31:4], 4'h0};
      return {4{base}};
   endfunction

   task automatic report_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
      $display("mismatch %s: expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
      mismatch_cnt++;
   endtask

   // Walk over once flushed flag is up and grant is back
   task automatic wait_flush_done();
      while (!(cache_is_flushed_o === 1'b1 && fetch_gnt_o === 1'b1))
         @(negedge clk_i);
   endtask

   // Called on a falling edge with the controller idle
   task automatic run_fetch(input icache_pkg::fetch_addr_t addr, input logic exp_hit);
      int                      latency;
      int                      refills_before;
      icache_pkg::fetch_addr_t line_addr;
      line_addr      = {addr[31:4], 4'h0};
      refills_before = refill_cnt;
      fetch_req_i    = 1'b1;
      fetch_addr_i   = addr;
      // Grant is combinational and needs a moment to settle
      #1;
      while (fetch_gnt_o !== 1'b1)
      begin
         @(negedge clk_i);
         #1;
      end
      @(negedge clk_i);
      fetch_req_i = 1'b0;
      // This falling edge lies one cycle after the grant cycle
      latency     = 1;
      while (fetch_rvalid_o !== 1'b1)
      begin
         @(negedge clk_i);
         latency++;
      end
      if (fetch_rdata_o !== line_data(addr))
         report_mismatch("fetch_rdata_o", line_data(addr), fetch_rdata_o);
      if (exp_hit)
      begin
         // Hit returns after a fixed latency
         if (latency != 2)
            report_mismatch("fetch_rvalid_o latency", 2, latency);
      end
      else
      begin
         if (refill_cnt != refills_before + 1)
            report_mismatch("refill_req_o count", refills_before + 1, refill_cnt);
         else if (last_refill_addr !== line_addr)
            report_mismatch("refill_addr_o", line_addr, last_refill_addr);
         // A cached refill clears the flushed flag
         if (!bypass_on && cache_is_flushed_o !== 1'b0)
            report_mismatch("cache_is_flushed_o", 0, cache_is_flushed_o);
      end
      if (cache_is_bypassed_o !== bypass_on)
         report_mismatch("cache_is_bypassed_o", bypass_on, cache_is_bypassed_o);
      @(negedge clk_i);
      if (fetch_rvalid_o !== 1'b0)
         report_mismatch("fetch_rvalid_o", 0, fetch_rvalid_o);
      // A hit leaves the program memory untouched
      if (exp_hit && refill_cnt != refills_before)
         report_mismatch("refill_req_o count", refills_before, refill_cnt);
   endtask

   task automatic change_bypass(input logic level);
      bypass_icache_i = level;
      bypass_on       = level;
      @(negedge clk_i);
      // Status follows once idle in the new mode and leaving goes through a flush
      while (!(cache_is_bypassed_o === level && fetch_gnt_o === 1'b1))
         @(negedge clk_i);
   endtask

   task automatic run_flush();
      flush_icache_i = 1'b1;
      @(negedge clk_i);
      flush_icache_i = 1'b0;
      wait_flush_done();
   endtask

   task automatic check_counters(input logic [31:0] trans, input logic [31:0] hits,
                                 input logic [31:0] misses);
      if (bank_trans_count_o !== trans)
         report_mismatch("bank_trans_count_o", trans, bank_trans_count_o);
      if (bank_hit_count_o !== hits)
         report_mismatch("bank_hit_count_o", hits, bank_hit_count_o);
      if (bank_miss_count_o !== misses)
         report_mismatch("bank_miss_count_o", misses, bank_miss_count_o);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Refill memory responder
   ////////////////////////////////////////////////////////////////////////////
   initial
   begin : refill_responder
      int                      gnt_delay;
      int                      resp_delay;
      icache_pkg::fetch_addr_t req_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      wait (rst_n_i === 1'b1);
      forever
      begin
         @(negedge clk_i);
         if (refill_req_o === 1'b1)
         begin
            req_addr         = refill_addr_o;
            last_refill_addr = req_addr;
            refill_cnt++;
            gnt_delay = int'(lfsr_take(2));
            // Request must hold while the grant is withheld
            repeat (gnt_delay)
            begin
               @(negedge clk_i);
               if (refill_addr_o !== req_addr)
                  report_mismatch("refill_addr_o", req_addr, refill_addr_o);
               if (refill_req_o !== 1'b1)
               begin
                  $display("refill request dropped before its grant at %0t", $time);
                  other_cnt++;
               end
            end
            refill_gnt_i = 1'b1;
            resp_delay   = int'(lfsr_take(2)) + 1;
            @(negedge clk_i);
            refill_gnt_i = 1'b0;
            repeat (resp_delay - 1) @(negedge clk_i);
            // Whole line in one pulse
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = line_data(req_addr);
            @(negedge clk_i);
            refill_r_valid_i = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Trace reader and sequence
   ////////////////////////////////////////////////////////////////////////////
   initial
   begin : main
      int          fd;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] addr;
      logic [31:0] val;
      clk_i              = 1'b0;
      rst_n_i            = 1'b0;
      fetch_req_i        = 1'b0;
      fetch_addr_i       = '0;
      bypass_icache_i    = 1'b0;
      flush_icache_i     = 1'b0;
      ctrl_clear_regs_i  = 1'b0;
      ctrl_enable_regs_i = 1'b1;
      fd = $fopen("bench/icache_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file bench/icache_trace.txt");
         $display("SOME TESTS FAILED");
         $finish;
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         // Blank and comment lines
         if (line.len() < 3 || line.getc(0) == "#")
            continue;
         if ($sscanf(line, "%c %h %h", cmd, addr, val) == 3)
         begin
            trace_cmd.push_back(cmd);
            trace_addr.push_back(addr);
            trace_val.push_back(val);
         end
      end
      $fclose(fd);
      trace_loaded = 1'b1;

      repeat (8) @(negedge clk_i);
      // Reset values
      if ({fetch_gnt_o, fetch_rvalid_o, refill_req_o, cache_is_bypassed_o,
           cache_is_flushed_o} !== 5'b0)
         report_mismatch("reset status outputs", 0, {fetch_gnt_o, fetch_rvalid_o,
                         refill_req_o, cache_is_bypassed_o, cache_is_flushed_o});
      check_counters(0, 0, 0);
      rst_n_i = 1'b1;
      // Flush walk out of reset
      wait_flush_done();

      for (int i = 0; i < trace_cmd.size(); i++)
      begin
         @(negedge clk_i);
         case (trace_cmd[i])
            "F": run_fetch(trace_addr[i], trace_val[i][0]);
            "B": change_bypass(trace_val[i][0]);
            "X": run_flush();
            "C": check_counters(trace_addr[i], trace_val[i][15:8], trace_val[i][7:0]);
            default:
            begin
               $display("unknown trace command %c in trace entry %0d", trace_cmd[i], i);
               other_cnt++;
            end
         endcase
      end

      // Clear zeroes all three counters
      @(negedge clk_i);
      ctrl_clear_regs_i = 1'b1;
      @(negedge clk_i);
      ctrl_clear_regs_i = 1'b0;
      check_counters(0, 0, 0);

      $display("run finished: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Budget of 40 cycles per trace entry plus reset and start-up flush
   initial
   begin : watchdog
      wait (trace_loaded === 1'b1);
      repeat (trace_cmd.size() * 40 + 200) @(posedge clk_i);
      $display("timeout: trace not finished after %0d cycles", trace_cmd.size() * 40 + 200);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- common/icache_array_if.sv
// Request and read data signals between the cache controller and the way banks
`timescale 1ns/1ps

interface icache_array_if;

   // Per way read and write strobes
   icache_pkg::way_vec_t                           tag_rd_req;
   icache_pkg::way_vec_t                           tag_wr_req;
   icache_pkg::way_vec_t                           data_rd_req;
   icache_pkg::way_vec_t                           data_wr_req;

   // Shared by tag and data arrays, reads and writes
   icache_pkg::set_idx_t                           set_idx;
   icache_pkg::tag_entry_t                         tag_wdata;
   icache_pkg::line_t                              data_wdata;

   // Registered read data, valid the cycle after a read strobe
   icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] tag_rdata;
   icache_pkg::line_t      [icache_pkg::NB_WAYS-1:0] data_rdata;

   // Controller side
   modport ctrl (
      output tag_rd_req, tag_wr_req, data_rd_req, data_wr_req,
      output set_idx, tag_wdata, data_wdata,
      input  tag_rdata, data_rdata
   );

   // Storage side
   modport array (
      input  tag_rd_req, tag_wr_req, data_rd_req, data_wr_req,
      input  set_idx, tag_wdata, data_wdata,
      output tag_rdata, data_rdata
   );

endinterface

//--- common/icache_pkg.sv
// Cache geometry, address field positions and payload types
package icache_pkg;

   // Fetch side widths, one fetch returns a whole line
   localparam int FETCH_ADDR_WIDTH = 32;
   localparam int FETCH_DATA_WIDTH = 128;

   // Associativity and capacity in bytes
   localparam int NB_WAYS          = 2;
   localparam int CACHE_SIZE       = 512;

   // One line per set in every way
   localparam int NUM_SETS         = CACHE_SIZE / (NB_WAYS * FETCH_DATA_WIDTH / 8);

   ////////////////////////////////////////////////////////////////////////////
   // Address split: | tag | set index | byte offset |
   ////////////////////////////////////////////////////////////////////////////
   localparam int OFFSET_WIDTH     = $clog2(FETCH_DATA_WIDTH / 8);
   localparam int SET_ID_LSB       = OFFSET_WIDTH;
   localparam int SET_ID_MSB       = SET_ID_LSB + $clog2(NUM_SETS) - 1;
   localparam int TAG_LSB          = SET_ID_MSB + 1;
   // Full tag, no reduction against the program memory size
   localparam int TAG_WIDTH        = FETCH_ADDR_WIDTH - TAG_LSB;

   typedef logic [FETCH_ADDR_WIDTH-1:0]      fetch_addr_t;
   typedef logic [FETCH_DATA_WIDTH-1:0]      line_t;
   typedef logic [SET_ID_MSB-SET_ID_LSB:0]   set_idx_t;
   // One bit per way, for enables and hit vectors
   typedef logic [NB_WAYS-1:0]               way_vec_t;

   // Tag array entry, valid bit on top
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_entry_t;

endpackage

//--- hw/icache_way_bank.sv
// Flop based storage for one cache way with registered read, payload given by type
`timescale 1ns/1ps

module icache_way_bank
#(
   parameter type payload_t = logic
)
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,

   input  logic                 rd_en_i,
   input  logic                 wr_en_i,
   input  icache_pkg::set_idx_t addr_i,
   input  payload_t             wdata_i,
   output payload_t             rdata_o
);

   // One entry per set
   payload_t entries_q [icache_pkg::NUM_SETS];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int s = 0; s < icache_pkg::NUM_SETS; s++)
         begin
            entries_q[s] <= '0;
         end
         rdata_o <= '0;
      end
      else
      begin
         // Write lands at this edge
         if (wr_en_i)
         begin
            entries_q[addr_i] <= wdata_i;
         end
         // Read data shows up next cycle and holds until the next read
         if (rd_en_i)
         begin
            rdata_o <= entries_q[addr_i];
         end
      end
   end

endmodule

//--- hw/pri_icache.sv
// Top level of the private instruction cache: controller, counters, way banks, refill buffer
`timescale 1ns/1ps

module pri_icache
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   // Fetch side
   input  logic                    fetch_req_i,
   input  icache_pkg::fetch_addr_t fetch_addr_i,
   output logic                    fetch_gnt_o,
   output logic                    fetch_rvalid_o,
   output icache_pkg::line_t       fetch_rdata_o,

   // Refill side
   output logic                    refill_req_o,
   output icache_pkg::fetch_addr_t refill_addr_o,
   input  logic                    refill_gnt_i,
   input  logic                    refill_r_valid_i,
   input  icache_pkg::line_t       refill_r_data_i,

   // Control
   input  logic                    bypass_icache_i,
   input  logic                    flush_icache_i,
   input  logic                    ctrl_clear_regs_i,
   input  logic                    ctrl_enable_regs_i,
   output logic                    cache_is_bypassed_o,
   output logic                    cache_is_flushed_o,

   // Statistics
   output logic [31:0]             bank_hit_count_o,
   output logic [31:0]             bank_trans_count_o,
   output logic [31:0]             bank_miss_count_o
);

   icache_array_if    arr_if ();

   logic              resp_valid;
   logic              resp_pop;
   icache_pkg::line_t resp_data;
   logic              hit_evt;
   logic              miss_evt;
   logic              trans_evt;

   ////////////////////////////////////////////////////////////////////////////
   // Controller and its counters
   ////////////////////////////////////////////////////////////////////////////
   pri_icache_controller i_pri_icache_controller
   (
      .clk_i               ( clk_i               ),
      .rst_n_i             ( rst_n_i             ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .resp_valid_i        ( resp_valid          ),
      .resp_data_i         ( resp_data           ),
      .resp_pop_o          ( resp_pop            ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .arr                 ( arr_if              ),
      .hit_o               ( hit_evt             ),
      .miss_o              ( miss_evt            ),
      .trans_o             ( trans_evt           )
   );

   icache_stat_counters i_icache_stat_counters
   (
      .clk_i         ( clk_i              ),
      .rst_n_i       ( rst_n_i            ),
      .hit_i         ( hit_evt            ),
      .miss_i        ( miss_evt           ),
      .trans_i       ( trans_evt          ),
      .clear_i       ( ctrl_clear_regs_i  ),
      .enable_i      ( ctrl_enable_regs_i ),
      .hit_count_o   ( bank_hit_count_o   ),
      .trans_count_o ( bank_trans_count_o ),
      .miss_count_o  ( bank_miss_count_o  )
   );

   ////////////////////////////////////////////////////////////////////////////
   // Tag and data way banks, array side of the interface
   ////////////////////////////////////////////////////////////////////////////
   for (genvar w = 0; w < icache_pkg::NB_WAYS; w++)
   begin : g_way
      icache_way_bank #(.payload_t(icache_pkg::tag_entry_t)) i_tag_bank
      (
         .clk_i   ( clk_i                ),
         .rst_n_i ( rst_n_i              ),
         .rd_en_i ( arr_if.tag_rd_req[w] ),
         .wr_en_i ( arr_if.tag_wr_req[w] ),
         .addr_i  ( arr_if.set_idx       ),
         .wdata_i ( arr_if.tag_wdata     ),
         .rdata_o ( arr_if.tag_rdata[w]  )
      );

      icache_way_bank #(.payload_t(icache_pkg::line_t)) i_data_bank
      (
         .clk_i   ( clk_i                 ),
         .rst_n_i ( rst_n_i               ),
         .rd_en_i ( arr_if.data_rd_req[w] ),
         .wr_en_i ( arr_if.data_wr_req[w] ),
         .addr_i  ( arr_if.set_idx        ),
         .wdata_i ( arr_if.data_wdata     ),
         .rdata_o ( arr_if.data_rdata[w]  )
      );
   end

   // Refill lines wait here until the controller is ready for them
   refill_resp_buffer i_refill_resp_buffer
   (
      .clk_i   ( clk_i            ),
      .rst_n_i ( rst_n_i          ),
      .valid_i ( refill_r_valid_i ),
      .data_i  ( refill_r_data_i  ),
      .pop_i   ( resp_pop         ),
      .valid_o ( resp_valid       ),
      .data_o  ( resp_data        )
   );

endmodule

//--- hw/refill_resp_buffer.sv
// Two entry FIFO that catches refill response lines until the controller takes them
`timescale 1ns/1ps

module refill_resp_buffer
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   // Memory side, no back pressure
   input  logic              valid_i,
   input  icache_pkg::line_t data_i,

   // Controller side
   input  logic              pop_i,
   output logic              valid_o,
   output icache_pkg::line_t data_o
);

   icache_pkg::line_t slots_q [2];
   logic              wr_ptr_q;
   logic              rd_ptr_q;
   logic [1:0]        count_q;

   // Head of queue straight from the slot
   assign valid_o = (count_q != 2'd0);
   assign data_o  = slots_q[rd_ptr_q];

   // Pointers and fill level
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (valid_i)
         begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop_i)
         begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         count_q <= count_q + {1'b0, valid_i} - {1'b0, pop_i};
      end
   end

   // Line storage
   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         slots_q[wr_ptr_q] <= data_i;
      end
   end

   // Memory must not run ahead of the controller by more than two lines
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i |-> (count_q != 2'd2));
   // Controller pops only what has arrived
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> (count_q != 2'd0));

endmodule

//--- icache_ctrl/icache_stat_counters.sv
// Hit, transaction and miss counters with clear and enable
`timescale 1ns/1ps

module icache_stat_counters
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   // One cycle event pulses from the controller
   input  logic        hit_i,
   input  logic        miss_i,
   input  logic        trans_i,

   input  logic        clear_i,
   input  logic        enable_i,

   output logic [31:0] hit_count_o,
   output logic [31:0] trans_count_o,
   output logic [31:0] miss_count_o
);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         hit_count_o   <= '0;
         trans_count_o <= '0;
         miss_count_o  <= '0;
      end
      else if (clear_i)
      begin
         // Clear beats a same cycle event
         hit_count_o   <= '0;
         trans_count_o <= '0;
         miss_count_o  <= '0;
      end
      else if (enable_i)
      begin
         hit_count_o   <= hit_count_o + {31'd0, hit_i};
         trans_count_o <= trans_count_o + {31'd0, trans_i};
         miss_count_o  <= miss_count_o + {31'd0, miss_i};
      end
   end

endmodule

//--- icache_ctrl/pri_icache_controller.sv
// Cache controller FSM: lookup, refill, bypass, flush walk and round robin victim
`timescale 1ns/1ps

module pri_icache_controller
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   // Fetch port from the core
   input  logic                    fetch_req_i,
   input  icache_pkg::fetch_addr_t fetch_addr_i,
   output logic                    fetch_gnt_o,
   output logic                    fetch_rvalid_o,
   output icache_pkg::line_t       fetch_rdata_o,

   // Refill request to program memory
   output logic                    refill_req_o,
   output icache_pkg::fetch_addr_t refill_addr_o,
   input  logic                    refill_gnt_i,

   // Refill data out of the response buffer
   input  logic                    resp_valid_i,
   input  icache_pkg::line_t       resp_data_i,
   output logic                    resp_pop_o,

   input  logic                    bypass_icache_i,
   input  logic                    flush_icache_i,
   output logic                    cache_is_bypassed_o,
   output logic                    cache_is_flushed_o,

   icache_array_if.ctrl            arr,

   // Statistic events
   output logic                    hit_o,
   output logic                    miss_o,
   output logic                    trans_o
);

   typedef enum logic [2:0] {
      S_IDLE, S_LOOKUP, S_BYPASS, S_REFILL_REQ, S_REFILL_WAIT, S_FLUSH
   } state_t;

   state_t                              state_q;
   state_t                              state_d;
   icache_pkg::fetch_addr_t             addr_q;
   logic [icache_pkg::TAG_WIDTH-1:0]    req_tag;
   icache_pkg::set_idx_t                req_set;
   icache_pkg::set_idx_t                flush_cnt_q;
   logic [$clog2(icache_pkg::NB_WAYS)-1:0] rr_q;
   icache_pkg::way_vec_t                victim_vec;
   icache_pkg::way_vec_t                hit_vec;
   icache_pkg::line_t                   hit_data;
   logic                                bypass_mode_q;
   logic                                bypass_change;
   logic                                accept;
   logic                                resp_take;
   logic                                line_fill;
   logic                                rvalid_q;
   logic                                bypassed_q;
   logic                                flushed_q;

   // Fields of the captured fetch address
   assign req_tag = addr_q[icache_pkg::FETCH_ADDR_WIDTH-1:icache_pkg::TAG_LSB];
   assign req_set = addr_q[icache_pkg::SET_ID_MSB:icache_pkg::SET_ID_LSB];

   // No grant while a flush request or a bypass change waits
   assign bypass_change = (bypass_icache_i != bypass_mode_q);
   assign fetch_gnt_o   = (state_q == S_IDLE) & ~flush_icache_i & ~bypass_change;
   assign accept        = fetch_req_i & fetch_gnt_o;

   assign resp_take     = (state_q == S_REFILL_WAIT) & resp_valid_i;
   assign resp_pop_o    = resp_take;
   // Bypassed lines never reach the arrays
   assign line_fill     = resp_take & ~bypass_mode_q;
   assign victim_vec    = icache_pkg::way_vec_t'(1) << rr_q;

   assign refill_req_o  = (state_q == S_REFILL_REQ);
   // Line aligned refill address
   assign refill_addr_o = {addr_q[icache_pkg::FETCH_ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH],
                           {icache_pkg::OFFSET_WIDTH{1'b0}}};

   assign trans_o = accept;
   assign hit_o   = (state_q == S_LOOKUP) & (hit_vec != '0);
   assign miss_o  = (state_q == S_LOOKUP) & (hit_vec == '0);

   assign fetch_rvalid_o      = rvalid_q;
   assign cache_is_bypassed_o = bypassed_q;
   assign cache_is_flushed_o  = flushed_q;

   ////////////////////////////////////////////////////////////////////////////
   // Tag compare
   ////////////////////////////////////////////////////////////////////////////
   always_comb
   begin
      hit_vec  = '0;
      hit_data = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (arr.tag_rdata[w].valid && (arr.tag_rdata[w].tag == req_tag))
         begin
            hit_vec[w] = 1'b1;
            hit_data   = hit_data | arr.data_rdata[w];
         end
      end
   end

   // Array strobes; set index follows whoever owns the arrays this cycle
   always_comb
   begin
      arr.tag_rd_req      = '0;
      arr.data_rd_req     = '0;
      arr.tag_wr_req      = '0;
      arr.data_wr_req     = '0;
      arr.set_idx         = req_set;
      arr.tag_wdata.valid = 1'b1;
      arr.tag_wdata.tag   = req_tag;
      arr.data_wdata      = resp_data_i;
      case (state_q)
         S_IDLE:
         begin
            // Read both ways in the grant cycle
            arr.set_idx     = fetch_addr_i[icache_pkg::SET_ID_MSB:icache_pkg::SET_ID_LSB];
            arr.tag_rd_req  = {icache_pkg::NB_WAYS{accept & ~bypass_mode_q}};
            arr.data_rd_req = {icache_pkg::NB_WAYS{accept & ~bypass_mode_q}};
         end
         S_REFILL_WAIT:
         begin
            arr.tag_wr_req  = line_fill ? victim_vec : '0;
            arr.data_wr_req = line_fill ? victim_vec : '0;
         end
         S_FLUSH:
         begin
            // Invalid entry into every way of one set per cycle
            arr.set_idx    = flush_cnt_q;
            arr.tag_wdata  = '0;
            arr.tag_wr_req = '1;
         end
         default:
         begin
            arr.set_idx = req_set;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
         begin
            // Leaving bypass forces a flush so stale lines cannot hit
            if (flush_icache_i || (bypass_change && bypass_mode_q))
               state_d = S_FLUSH;
            else if (accept)
               state_d = bypass_mode_q ? S_BYPASS : S_LOOKUP;
         end
         S_LOOKUP:      state_d = (hit_vec != '0) ? S_IDLE : S_REFILL_REQ;
         S_BYPASS:      state_d = S_REFILL_REQ;
         S_REFILL_REQ:  state_d = refill_gnt_i ? S_REFILL_WAIT : S_REFILL_REQ;
         S_REFILL_WAIT: state_d = resp_valid_i ? S_IDLE : S_REFILL_WAIT;
         S_FLUSH:
         begin
            if (flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::NUM_SETS - 1))
               state_d = S_IDLE;
         end
         default:       state_d = S_IDLE;
      endcase
   end

   // Control state; a flush walk starts out of reset
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q       <= S_FLUSH;
         flush_cnt_q   <= '0;
         rr_q          <= '0;
         bypass_mode_q <= 1'b0;
         bypassed_q    <= 1'b0;
         flushed_q     <= 1'b0;
         rvalid_q      <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         rvalid_q <= hit_o | resp_take;
         // Mode and its status flag only move while idle
         if (state_q == S_IDLE)
         begin
            bypass_mode_q <= bypass_icache_i;
            bypassed_q    <= bypass_mode_q;
         end
         if (state_q == S_FLUSH)
            flush_cnt_q <= flush_cnt_q + 1'b1;
         if ((state_q == S_FLUSH) && (state_d == S_IDLE))
            flushed_q <= 1'b1;
         else if (line_fill)
         begin
            flushed_q <= 1'b0;
            rr_q      <= rr_q + 1'b1;
         end
      end
   end

   // Fetch address and returned line
   always_ff @(posedge clk_i)
   begin
      if (accept)
         addr_q <= fetch_addr_i;
      if (hit_o)
         fetch_rdata_o <= hit_data;
      else if (resp_take)
         fetch_rdata_o <= resp_data_i;
   end

   // Refills go to distinct ways, so a line is never resident twice
   a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q == S_LOOKUP) |-> $onehot0(hit_vec));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_pri_icache -o tb_pri_icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pri_icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
common/icache_pkg.sv
common/icache_array_if.sv
hw/icache_way_bank.sv
hw/refill_resp_buffer.sv
icache_ctrl/icache_stat_counters.sv
icache_ctrl/pri_icache_controller.sv
hw/pri_icache.sv
bench/tb_pri_icache.sv
